//--- Bender.yml
package:
  name: l2_cache

sources:
  - lc3b_types.sv
  - cache_ctrl_types.sv
  - cache_way.sv
  - l2_cache_datapath.sv
  - l2_cache_control.sv
  - l2_cache.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - pmem_model.sv
      - l2_cache_tb.sv

//--- cache_ctrl_types.sv
package cache_ctrl_types;

	import lc3b_types::*;

	typedef enum logic [1:0] {
		s_check,
		s_write_back,
		s_allocate
	} cache_state_t;

	typedef struct packed {
		logic line_write;
		logic tag_write;    // Also sets valid
		logic dirty_write;
		logic dirty_in;
	} way_ctrl_t;

	typedef struct packed {
		logic     match;  // Valid and tag equal
		logic     dirty;
		lc3b_tag  tag;
		lc3b_data line;
	} way_status_t;

	typedef struct packed {
		way_ctrl_t way0;
		way_ctrl_t way1;
		logic      lru_write;
		logic      fill_sel;     // 1 selects memory data
		logic      wb_addr_sel;  // 1 selects write-back address
	} dp_ctrl_t;

	typedef struct packed {
		logic hit;
		logic hit_way;
		logic victim_way;
		logic victim_dirty;
	} dp_status_t;

	// Per-way write commands used by the controller
	localparam way_ctrl_t WAY_IDLE = '0;
	localparam way_ctrl_t WAY_HIT_WRITE = '{line_write: 1'b1, tag_write: 1'b0,
		dirty_write: 1'b1, dirty_in: 1'b1};
	localparam way_ctrl_t WAY_FILL = '{line_write: 1'b1, tag_write: 1'b1,
		dirty_write: 1'b1, dirty_in: 1'b0};

endpackage : cache_ctrl_types

//--- cache_way.sv
module cache_way import lc3b_types::*, cache_ctrl_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  way_ctrl_t   ctrl,
	input  lc3b_tag     tag,
	input  lc3b_index   index,
	input  lc3b_data    line_in,
	output way_status_t status
);

	logic [NUM_SETS-1:0] valid;
	logic [NUM_SETS-1:0] dirty;
	lc3b_tag             tags  [NUM_SETS];
	lc3b_data            lines [NUM_SETS];

	logic     valid_rd;
	logic     dirty_rd;
	lc3b_tag  tag_rd;
	lc3b_data line_rd;

	// Valid bits are the only per-way state cleared by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (ctrl.tag_write) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.dirty_write) begin
			dirty[index] <= ctrl.dirty_in;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.tag_write) begin
			tags[index] <= tag;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.line_write) begin
			lines[index] <= line_in;
		end
	end

	// Combinational read at the current index
	assign valid_rd = valid[index];
	assign dirty_rd = dirty[index];
	assign tag_rd   = tags[index];
	assign line_rd  = lines[index];

	always_comb begin
		status.match = valid_rd && (tag_rd == tag);
		status.dirty = valid_rd && dirty_rd;  // An invalid line never needs write-back
		status.tag   = tag_rd;
		status.line  = line_rd;
	end

endmodule : cache_way

//--- files.f
lc3b_types.sv
cache_ctrl_types.sv
cache_way.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
tb_clock_gen.sv
pmem_model.sv
l2_cache_tb.sv

//--- l2_cache.sv
module l2_cache import lc3b_types::*, cache_ctrl_types::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  lc3b_word      mem_address,
	input  logic          mem_read,
	input  logic          mem_write,
	input  lc3b_data      mem_wdata,
	input  lc3b_line_mask mem_byte_enable,
	output lc3b_data      mem_rdata,
	output logic          mem_resp,
	output lc3b_word      pmem_address,
	output logic          pmem_read,
	output logic          pmem_write,
	output lc3b_data      pmem_wdata,
	input  lc3b_data      pmem_rdata,
	input  logic          pmem_resp
);

	dp_ctrl_t   dp_ctrl;
	dp_status_t dp_status;

	l2_cache_control control (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.pmem_resp  (pmem_resp),
		.status     (dp_status),
		.ctrl       (dp_ctrl),
		.mem_resp   (mem_resp),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write)
	);

	l2_cache_datapath datapath (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.pmem_rdata      (pmem_rdata),
		.ctrl            (dp_ctrl),
		.status          (dp_status),
		.mem_rdata       (mem_rdata),
		.pmem_wdata      (pmem_wdata),
		.pmem_address    (pmem_address)
	);

endmodule : l2_cache

//--- l2_cache_control.sv
module l2_cache_control import lc3b_types::*, cache_ctrl_types::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       mem_read,
	input  logic       mem_write,
	input  logic       pmem_resp,
	input  dp_status_t status,
	output dp_ctrl_t   ctrl,
	output logic       mem_resp,
	output logic       pmem_read,
	output logic       pmem_write
);

	cache_state_t state;
	cache_state_t next_state;
	logic         request;

	assign request = mem_read || mem_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_check;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state       = state;
		mem_resp         = 1'b0;
		pmem_read        = 1'b0;
		pmem_write       = 1'b0;
		ctrl.way0        = WAY_IDLE;
		ctrl.way1        = WAY_IDLE;
		ctrl.lru_write   = 1'b0;
		ctrl.fill_sel    = 1'b0;
		ctrl.wb_addr_sel = 1'b0;

		case (state)
			s_check: begin
				if (request && status.hit) begin
					mem_resp       = 1'b1;  // Answered in the request cycle
					ctrl.lru_write = 1'b1;
					if (mem_write) begin
						if (status.hit_way) begin
							ctrl.way1 = WAY_HIT_WRITE;
						end else begin
							ctrl.way0 = WAY_HIT_WRITE;
						end
					end
				end else if (request) begin
					if (status.victim_dirty) begin
						next_state = s_write_back;
					end else begin
						next_state = s_allocate;
					end
				end
			end

			s_write_back: begin
				pmem_write       = 1'b1;
				ctrl.wb_addr_sel = 1'b1;
				if (pmem_resp) begin
					next_state = s_allocate;
				end
			end

			s_allocate: begin
				pmem_read     = 1'b1;
				ctrl.fill_sel = 1'b1;
				if (pmem_resp) begin
					// Victim takes the line, tag and valid, dirty cleared
					if (status.victim_way) begin
						ctrl.way1 = WAY_FILL;
					end else begin
						ctrl.way0 = WAY_FILL;
					end
					next_state = s_check;  // Request hits on the next cycle
				end
			end

			default: begin
				next_state = s_check;
			end
		endcase
	end

endmodule : l2_cache_control

//--- l2_cache_datapath.sv
module l2_cache_datapath import lc3b_types::*, cache_ctrl_types::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  lc3b_word      mem_address,
	input  lc3b_data      mem_wdata,
	input  lc3b_line_mask mem_byte_enable,
	input  lc3b_data      pmem_rdata,
	input  dp_ctrl_t      ctrl,
	output dp_status_t    status,
	output lc3b_data      mem_rdata,
	output lc3b_data      pmem_wdata,
	output lc3b_word      pmem_address
);

	lc3b_tag   tag;
	lc3b_index index;

	way_status_t way0_status;
	way_status_t way1_status;

	logic [NUM_SETS-1:0] lru;  // Points at the way to evict next
	logic                lru_rd;

	logic     hit_way;
	lc3b_data hit_line;
	lc3b_data merged_line;
	lc3b_data line_in;
	lc3b_tag  victim_tag;
	lc3b_word line_addr;
	lc3b_word wb_addr;

	assign tag   = mem_address[TAG_LSB +: TAG_W];
	assign index = mem_address[INDEX_LSB +: INDEX_W];

	cache_way way0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ctrl.way0),
		.tag     (tag),
		.index   (index),
		.line_in (line_in),
		.status  (way0_status)
	);

	cache_way way1 (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctrl    (ctrl.way1),
		.tag     (tag),
		.index   (index),
		.line_in (line_in),
		.status  (way1_status)
	);

	assign lru_rd = lru[index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lru <= '0;
		end else if (ctrl.lru_write) begin
			lru[index] <= ~hit_way;  // Other way becomes the victim
		end
	end

	assign hit_way  = way1_status.match;
	assign hit_line = hit_way ? way1_status.line : way0_status.line;

	always_comb begin
		status.hit          = way0_status.match || way1_status.match;
		status.hit_way      = hit_way;
		status.victim_way   = lru_rd;
		status.victim_dirty = lru_rd ? way1_status.dirty : way0_status.dirty;
	end

	// Byte-enable merge of the upper-level data over the hitting line
	always_comb begin
		merged_line = hit_line;
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (mem_byte_enable[b]) begin
				merged_line[8*b +: 8] = mem_wdata[8*b +: 8];
			end
		end
	end

	assign line_in   = ctrl.fill_sel ? pmem_rdata : merged_line;
	assign mem_rdata = hit_line;

	assign victim_tag = lru_rd ? way1_status.tag : way0_status.tag;
	assign pmem_wdata = lru_rd ? way1_status.line : way0_status.line;

	assign line_addr    = {mem_address[WORD_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
	assign wb_addr      = {victim_tag, index, {INDEX_LSB{1'b0}}};
	assign pmem_address = ctrl.wb_addr_sel ? wb_addr : line_addr;

endmodule : l2_cache_datapath

//--- l2_cache_tb.sv
module l2_cache_tb import lc3b_types::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES    = 10;
	localparam int IDLE_CYCLES     = 5;
	localparam int NUM_REQUESTS    = 14;
	localparam int MAX_MISS_CYCLES = 20;
	localparam int CLK_PERIOD      = 100;

	logic          clk;
	logic          rst_n;
	lc3b_word      mem_address;
	logic          mem_read;
	logic          mem_write;
	lc3b_data      mem_wdata;
	lc3b_line_mask mem_byte_enable;
	lc3b_data      mem_rdata;
	logic          mem_resp;
	lc3b_word      pmem_address;
	logic          pmem_read;
	logic          pmem_write;
	lc3b_data      pmem_wdata;
	lc3b_data      pmem_rdata;
	logic          pmem_resp;

	integer   seed = 32'h12476ad4;
	int       errors = 0;
	int       tests_ok = 0;
	int       tests_failed = 0;
	int       test_errors;
	string    cur_test;
	lc3b_data exp_rdata;
	lc3b_data shadow [lc3b_word];  // Upper-level view of memory

	tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

	l2_cache uut (
		.clk(clk), .rst_n(rst_n),
		.mem_address(mem_address), .mem_read(mem_read), .mem_write(mem_write),
		.mem_wdata(mem_wdata), .mem_byte_enable(mem_byte_enable),
		.mem_rdata(mem_rdata), .mem_resp(mem_resp),
		.pmem_address(pmem_address), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	pmem_model mem (
		.clk(clk), .rst_n(rst_n),
		.pmem_address(pmem_address), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	// The cache stays quiet during reset and with no request pending
	assert property (@(posedge clk)
		(!rst_n || (!mem_read && !mem_write)) |-> (!mem_resp && !pmem_read && !pmem_write))
	else begin
		errors++;
		$display("Cache outputs were active with no request at %0t", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(mem_resp && mem_read) |-> (mem_rdata == exp_rdata))
	else begin
		errors++;
		$display("Fail %s: mem_rdata expected %h actual %h", cur_test,
			$sampled(exp_rdata), $sampled(mem_rdata));
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read && !pmem_resp) |=> (pmem_read && $stable(pmem_address)))
	else begin
		errors++;
		$display("Memory read dropped or its address moved before pmem_resp");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_write && !pmem_resp) |=>
		(pmem_write && $stable(pmem_address) && $stable(pmem_wdata)))
	else begin
		errors++;
		$display("Memory write dropped or its address or data moved before pmem_resp");
	end

	function automatic lc3b_word line_addr(lc3b_tag tag, lc3b_index index);
		return {tag, index, lc3b_offset'(0), 1'b0};
	endfunction

	function automatic lc3b_data rule_line(lc3b_word addr);
		lc3b_data line;
		for (int w = 0; w < 8; w++) begin
			line[16*w +: 16] = addr + lc3b_word'(w);
		end
		return line;
	endfunction

	function automatic lc3b_data expected_line(lc3b_word addr);
		return shadow.exists(addr) ? shadow[addr] : rule_line(addr);
	endfunction

	function automatic lc3b_data apply_mask(lc3b_data old, lc3b_data data, lc3b_line_mask mask);
		lc3b_data line;
		line = old;
		for (int b = 0; b < 16; b++) begin
			if (mask[b]) begin
				line[8*b +: 8] = data[8*b +: 8];
			end
		end
		return line;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			errors++;
			$display("Fail %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_line(input string what, input lc3b_data expected, input lc3b_data actual);
		assert (expected == actual) else begin
			errors++;
			$display("Fail %s %s: expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			tests_ok++;
			$display("%s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s: failed", cur_test);
		end
	endtask

	task automatic do_request(input lc3b_word addr, input logic wr, input lc3b_data data,
			input lc3b_line_mask mask);
		int cycles;
		cycles = 0;
		@(posedge clk);
		mem_address     <= addr;
		mem_read        <= !wr;
		mem_write       <= wr;
		mem_wdata       <= data;
		mem_byte_enable <= mask;
		@(negedge clk);
		while (!mem_resp) begin
			cycles++;
			if (cycles > MAX_MISS_CYCLES) begin
				abort_run($sformatf("No mem_resp for request to %h in %s", addr, cur_test));
			end
			@(negedge clk);
		end
		@(posedge clk);
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
		@(negedge clk);  // Lets the response checks settle
	endtask

	task automatic read_line(input lc3b_word addr);
		exp_rdata = expected_line(addr);
		do_request(addr, 1'b0, '0, '0);
	endtask

	task automatic write_line(input lc3b_word addr, input lc3b_data data, input lc3b_line_mask mask);
		do_request(addr, 1'b1, data, mask);
		shadow[addr] = apply_mask(expected_line(addr), data, mask);
	endtask

	initial begin
		#((RESET_CYCLES + IDLE_CYCLES + NUM_REQUESTS * MAX_MISS_CYCLES) * CLK_PERIOD);
		abort_run("Watchdog expired before all tests finished");
	end

	initial begin
		lc3b_word      addr_a;
		lc3b_word      addr_b;
		lc3b_word      addr_c;
		lc3b_word      addr_d;
		lc3b_word      addr_e;
		lc3b_word      addr_f;
		lc3b_word      addr_g;
		lc3b_data      wdata;
		lc3b_line_mask mask;
		int            reads;
		int            writes;

		mem_address     = '0;
		mem_read        = 1'b0;
		mem_write       = 1'b0;
		mem_wdata       = '0;
		mem_byte_enable = '0;
		exp_rdata       = '0;

		addr_a = line_addr(8'h3c, 4'h2);
		addr_b = line_addr(8'h11, 4'h5);  // B, C and D share a set
		addr_c = line_addr(8'h22, 4'h5);
		addr_d = line_addr(8'h33, 4'h5);
		addr_e = line_addr(8'h4a, 4'h9);
		addr_f = line_addr(8'h5b, 4'h9);
		addr_g = line_addr(8'h6c, 4'h9);

		begin_test("reset");
		@(posedge rst_n);
		repeat (IDLE_CYCLES) @(negedge clk);
		end_test();

		begin_test("read_miss_fill");
		reads = mem.read_count;
		read_line(addr_a);
		check_count("memory reads", reads + 1, mem.read_count);
		check_count("memory read address", addr_a, mem.last_read_addr);
		end_test();

		begin_test("read_hit");
		reads  = mem.read_count;
		writes = mem.write_count;
		read_line(addr_a);
		check_count("memory reads", reads, mem.read_count);
		check_count("memory writes", writes, mem.write_count);
		end_test();

		begin_test("write_hit_merge");
		reads  = mem.read_count;
		writes = mem.write_count;
		wdata  = {$random(seed), $random(seed), $random(seed), $random(seed)};
		mask   = lc3b_line_mask'($random(seed));
		write_line(addr_a, wdata, mask);
		read_line(addr_a);
		check_count("memory reads", reads, mem.read_count);
		check_count("memory writes", writes, mem.write_count);
		end_test();

		begin_test("lru_replacement");
		read_line(addr_b);
		read_line(addr_c);
		read_line(addr_b);  // C becomes least recently used
		read_line(addr_d);
		reads = mem.read_count;
		read_line(addr_b);
		check_count("memory reads after B", reads, mem.read_count);
		read_line(addr_c);
		check_count("memory reads after C", reads + 1, mem.read_count);
		end_test();

		begin_test("dirty_write_back");
		wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
		mask  = lc3b_line_mask'($random(seed));
		write_line(addr_e, wdata, mask);
		writes = mem.write_count;
		read_line(addr_f);
		read_line(addr_g);
		check_count("memory writes", writes + 1, mem.write_count);
		check_count("write-back address", addr_e, mem.write_addrs[$]);
		check_line("write-back data", expected_line(addr_e), mem.write_lines[$]);
		reads = mem.read_count;
		read_line(addr_e);
		check_count("memory reads", reads + 1, mem.read_count);
		end_test();

		$display("Summary: %0d ok, %0d failing, %0d check errors", tests_ok, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule : l2_cache_tb

//--- lc3b_types.sv
package lc3b_types;

	localparam int WORD_W     = 16;
	localparam int LINE_W     = 128;
	localparam int LINE_BYTES = LINE_W / 8;
	localparam int TAG_W      = 8;
	localparam int INDEX_W    = 4;
	localparam int OFFSET_W   = 3;

	localparam int NUM_SETS  = 16;
	localparam int TAG_LSB   = 8;
	localparam int INDEX_LSB = 4;  // Also the number of byte address bits in a line

	typedef logic [WORD_W-1:0]     lc3b_word;
	typedef logic [LINE_W-1:0]     lc3b_data;
	typedef logic [TAG_W-1:0]      lc3b_tag;
	typedef logic [INDEX_W-1:0]    lc3b_index;
	typedef logic [OFFSET_W-1:0]   lc3b_offset;  // Word within a line
	typedef logic [LINE_BYTES-1:0] lc3b_line_mask;

endpackage : lc3b_types

//--- pmem_model.sv
module pmem_model import lc3b_types::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  lc3b_word pmem_address,
	input  logic     pmem_read,
	input  logic     pmem_write,
	input  lc3b_data pmem_wdata,
	output lc3b_data pmem_rdata,
	output logic     pmem_resp
);

	timeunit 1ns;
	timeprecision 1ps;

	integer   seed = 32'h12476ad4;
	lc3b_data store [lc3b_word];  // Written lines by line address
	int       wait_cnt;
	logic     busy;

	int       read_count = 0;
	int       write_count = 0;
	lc3b_word last_read_addr;
	lc3b_word write_addrs [$];
	lc3b_data write_lines [$];

	// Untouched memory holds the line address plus the word number in every word
	function automatic lc3b_data initial_line(lc3b_word line_addr);
		lc3b_data line;
		for (int w = 0; w < 8; w++) begin
			line[16*w +: 16] = line_addr + lc3b_word'(w);
		end
		return line;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pmem_resp  <= 1'b0;
			pmem_rdata <= '0;
			busy       <= 1'b0;
			wait_cnt   <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if (busy) begin
				if (wait_cnt > 1) begin
					wait_cnt <= wait_cnt - 1;
				end else begin
					busy      <= 1'b0;
					pmem_resp <= 1'b1;
					if (pmem_write) begin
						store[pmem_address] = pmem_wdata;
						write_count++;
						write_addrs.push_back(pmem_address);
						write_lines.push_back(pmem_wdata);
					end else begin
						read_count++;
						last_read_addr = pmem_address;
						pmem_rdata <= store.exists(pmem_address) ? store[pmem_address]
							: initial_line(pmem_address);
					end
				end
			end else if (!pmem_resp && (pmem_read || pmem_write)) begin
				busy     <= 1'b1;
				wait_cnt <= 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6 cycles
			end
		end
	end

endmodule : pmem_model

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD  = 50;  // 100 ns clock
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule : tb_clock_gen
